// File: dmaCtrl_defs.svh
`ifndef DMA_CTRL_DEFS_SVH
`define DMA_CTRL_DEFS_SVH

// address bus and register width
`define DMA_ADR_W 16

// data word width on both ports and in the FIFO
`define DMA_DATA_W 16

// number of shift stages between reader and writer
`define DMA_FIFO_DEPTH 4

// width of the address field that selects the port
`define DMA_NIBBLE_W 4

// top nibble value of an internal address
`define DMA_INT_NIBBLE 4'hF

`endif

// File: dmaPkg.sv
`default_nettype none

package dmaPkg;

  // host register select codes
  typedef enum logic [2:0] {
    REG_CTRL    = 3'd0, // bit 0 is the enable
    REG_SRC_IDX = 3'd1,
    REG_SRC_MOD = 3'd2,
    REG_SRC_CNT = 3'd3,
    REG_DST_IDX = 3'd4,
    REG_DST_MOD = 3'd5,
    REG_DST_CNT = 3'd6
  } regSelT;

  // which memory port a request goes to
  typedef enum logic {
    PORT_INT = 1'b0, // NP
    PORT_EXT = 1'b1  // SP
  } portSelT;

  // enable bit life cycle
  // running lasts until the reader is finished,
  // draining until the writer has emptied the FIFO
  typedef enum logic [1:0] {
    XFER_IDLE  = 2'd0,
    XFER_RUN   = 2'd1,
    XFER_DRAIN = 2'd2
  } xferStateT;

endpackage

`default_nettype wire

// File: dmaRegFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmaCtrl_defs.svh"

module dmaRegFile
  import dmaPkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  regWrite,
  input  var  regSelT          regSel,
  input  wire [`DMA_ADR_W-1:0] regData,
  input  wire                  srcDone,
  input  wire                  dstDone,
  input  wire                  fifoEmpty,
  output logic [`DMA_ADR_W-1:0] srcIdx,
  output logic [`DMA_ADR_W-1:0] srcMod,
  output logic [`DMA_ADR_W-1:0] srcCnt,
  output logic [`DMA_ADR_W-1:0] dstIdx,
  output logic [`DMA_ADR_W-1:0] dstMod,
  output logic [`DMA_ADR_W-1:0] dstCnt,
  output logic                  start,
  output logic                  active,
  output logic                  done
);

  xferStateT state;
  logic      ctrlWr;

  assign ctrlWr = regWrite && (regSel == REG_CTRL);
  assign active = (state != XFER_IDLE); // the enable bit

  // transfer parameters, only writable while idle
  always_ff @(posedge clk)
  begin
    if (regWrite && state == XFER_IDLE)
    begin
      case (regSel)
        REG_SRC_IDX: srcIdx <= regData;
        REG_SRC_MOD: srcMod <= regData;
        REG_SRC_CNT: srcCnt <= regData;
        REG_DST_IDX: dstIdx <= regData;
        REG_DST_MOD: dstMod <= regData;
        REG_DST_CNT: dstCnt <= regData;
        default: ; // ctrl handled by the state register
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= XFER_IDLE;
      start <= 1'b0;
      done  <= 1'b0;
    end
    else
    begin
      start <= 1'b0;
      done  <= 1'b0;
      case (state)
        XFER_IDLE:
        begin
          if (ctrlWr && regData[0])
          begin
            state <= XFER_RUN;
            start <= 1'b1; // reader and writer load next edge
          end
        end
        XFER_RUN:
        begin
          if (ctrlWr && !regData[0])
            state <= XFER_IDLE; // abort, no done
          else if (!start && srcDone)
            state <= XFER_DRAIN;
        end
        XFER_DRAIN:
        begin
          if (ctrlWr && !regData[0])
            state <= XFER_IDLE;
          else if (dstDone && fifoEmpty)
          begin
            state <= XFER_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= XFER_IDLE;
      endcase
    end
  end

  doneNotStart: assert property (@(posedge clk) disable iff (rst) !(done && start));

endmodule

`default_nettype wire

// File: fifoStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmaCtrl_defs.svh"

module fifoStage
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   prevValid,
  input  wire [`DMA_DATA_W-1:0] prevData,
  input  wire                   nextTake,
  output logic                  valid,
  output logic [`DMA_DATA_W-1:0] data,
  output logic                  take
);

  // free now, or freed by the stage ahead this edge
  assign take = !valid || nextTake;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      valid <= 1'b0;
    else if (take)
      valid <= prevValid; // bubble moves in when nothing arrives
  end

  always_ff @(posedge clk)
  begin
    if (take && prevValid)
      data <= prevData;
  end

  // an offered word that is refused must still be offered next cycle
  noOverwrite: assert property (@(posedge clk) disable iff (rst)
    (prevValid && !take) |=> (prevValid && $stable(prevData)));

endmodule

`default_nettype wire

// File: sourceReader.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmaCtrl_defs.svh"

module sourceReader
  import dmaPkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   start,
  input  wire                   active,
  input  wire [`DMA_ADR_W-1:0]  srcIdx,
  input  wire [`DMA_ADR_W-1:0]  srcMod,
  input  wire [`DMA_ADR_W-1:0]  srcCnt,
  input  wire                   rdGrant,
  input  wire [`DMA_DATA_W-1:0] portDataIn,
  input  wire                   stageReady,
  output logic                  rdReq,
  output portSelT               rdPort,
  output logic [`DMA_ADR_W-1:0] rdAdr,
  output logic                  inValid,
  output logic [`DMA_DATA_W-1:0] inData,
  output logic                  srcDone
);

  logic [`DMA_ADR_W-1:0]  cnt;
  logic                   pending;   // read accepted last edge, data on the bus now
  logic                   holdValid;
  logic [`DMA_DATA_W-1:0] holdData;

  assign rdPort = (rdAdr[`DMA_ADR_W-1 -: `DMA_NIBBLE_W] == `DMA_INT_NIBBLE) ?
                  PORT_INT : PORT_EXT;

  // only one word in flight between the port and stage 0
  assign rdReq   = active && (cnt != '0) && !pending && !holdValid && stageReady;
  assign inValid = active && (pending || holdValid);
  assign inData  = holdValid ? holdData : portDataIn;
  assign srcDone = (cnt == '0) && !pending && !holdValid;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rdAdr     <= '0;
      cnt       <= '0;
      pending   <= 1'b0;
      holdValid <= 1'b0;
    end
    else if (start)
    begin
      rdAdr     <= srcIdx;
      cnt       <= srcCnt;
      pending   <= 1'b0;
      holdValid <= 1'b0;
    end
    else if (!active)
    begin
      cnt       <= '0; // aborted, late data is dropped
      pending   <= 1'b0;
      holdValid <= 1'b0;
    end
    else
    begin
      pending <= rdReq && rdGrant;
      if (rdReq && rdGrant)
      begin
        rdAdr <= rdAdr + srcMod;
        cnt   <= cnt - 1'b1;
      end
      if (pending && !stageReady)
        holdValid <= 1'b1; // stage 0 blocked, park the word
      else if (holdValid && stageReady)
        holdValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pending)
      holdData <= portDataIn;
  end

  // a grant is only ever given to a live request with words left
  cntStaysZero: assert property (@(posedge clk) disable iff (rst)
    rdGrant |-> (rdReq && cnt != '0));

endmodule

`default_nettype wire

// File: destWriter.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmaCtrl_defs.svh"

module destWriter
  import dmaPkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   start,
  input  wire                   active,
  input  wire [`DMA_ADR_W-1:0]  dstIdx,
  input  wire [`DMA_ADR_W-1:0]  dstMod,
  input  wire [`DMA_ADR_W-1:0]  dstCnt,
  input  wire                   headValid,
  input  wire [`DMA_DATA_W-1:0] headData,
  input  wire                   wrGrant,
  output logic                  wrReq,
  output portSelT               wrPort,
  output logic [`DMA_ADR_W-1:0] wrAdr,
  output logic [`DMA_DATA_W-1:0] wrData,
  output logic                  headTake,
  output logic                  dstDone
);

  logic [`DMA_ADR_W-1:0] cnt;

  assign wrPort = (wrAdr[`DMA_ADR_W-1 -: `DMA_NIBBLE_W] == `DMA_INT_NIBBLE) ?
                  PORT_INT : PORT_EXT;

  assign wrReq   = active && headValid && (cnt != '0);
  assign wrData  = headData; // head is frozen until popped
  assign dstDone = (cnt == '0);

  // pop on grant; surplus or aborted words are flushed without a write
  assign headTake = (wrReq && wrGrant) || (headValid && (!active || cnt == '0));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wrAdr <= '0;
      cnt   <= '0;
    end
    else if (start)
    begin
      wrAdr <= dstIdx;
      cnt   <= dstCnt;
    end
    else if (!active)
      cnt <= '0;
    else if (wrReq && wrGrant)
    begin
      wrAdr <= wrAdr + dstMod;
      cnt   <= cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: portArbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmaCtrl_defs.svh"

module portArbiter
  import dmaPkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   rdReq,
  input  var  portSelT          rdPort,
  input  wire [`DMA_ADR_W-1:0]  rdAdr,
  input  wire                   wrReq,
  input  var  portSelT          wrPort,
  input  wire [`DMA_ADR_W-1:0]  wrAdr,
  input  wire [`DMA_DATA_W-1:0] wrData,
  input  wire                   NP_busy,
  input  wire                   SP_busy,
  input  wire [`DMA_DATA_W-1:0] NPD_IN,
  input  wire [`DMA_DATA_W-1:0] SPD_IN,
  output logic                  rdGrant,
  output logic                  wrGrant,
  output logic                  NP_en,
  output logic                  NP_wrRd,
  output logic [`DMA_ADR_W-1:0] NPA,
  output logic [`DMA_DATA_W-1:0] NPD_OUT,
  output logic                  SP_en,
  output logic                  SP_wrRd,
  output logic [`DMA_ADR_W-1:0] SPA,
  output logic [`DMA_DATA_W-1:0] SPD_OUT,
  output logic [`DMA_DATA_W-1:0] rdData
);

  logic    rdHoldNp;  // read stalled on NP last cycle
  logic    rdHoldSp;
  logic    rdKeeps;
  logic    rdWins;
  logic    wrWins;
  portSelT rdPortQ;   // port of the last granted read

  // writer first, unless a stalled read already owns the port
  assign rdKeeps = (rdPort == PORT_INT) ? rdHoldNp : rdHoldSp;
  assign rdWins  = rdReq && (!wrReq || rdPort != wrPort || rdKeeps);
  assign wrWins  = wrReq && (!rdReq || rdPort != wrPort || !rdKeeps);

  assign rdGrant = rdWins && !((rdPort == PORT_INT) ? NP_busy : SP_busy);
  assign wrGrant = wrWins && !((wrPort == PORT_INT) ? NP_busy : SP_busy);

  assign rdData = (rdPortQ == PORT_INT) ? NPD_IN : SPD_IN;

  always_comb
  begin
    NP_en   = 1'b0;
    NP_wrRd = 1'b0;
    NPA     = '0;
    NPD_OUT = '0;
    SP_en   = 1'b0;
    SP_wrRd = 1'b0;
    SPA     = '0;
    SPD_OUT = '0;
    if (wrWins && wrPort == PORT_INT)
    begin
      NP_en   = 1'b1;
      NP_wrRd = 1'b1;
      NPA     = wrAdr;
      NPD_OUT = wrData;
    end
    else if (wrWins)
    begin
      SP_en   = 1'b1;
      SP_wrRd = 1'b1;
      SPA     = wrAdr;
      SPD_OUT = wrData;
    end
    if (rdWins && rdPort == PORT_INT)
    begin
      NP_en = 1'b1; // read, wrRd stays low
      NPA   = rdAdr;
    end
    else if (rdWins)
    begin
      SP_en = 1'b1;
      SPA   = rdAdr;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rdHoldNp <= 1'b0;
      rdHoldSp <= 1'b0;
      rdPortQ  <= PORT_INT;
    end
    else
    begin
      rdHoldNp <= rdWins && (rdPort == PORT_INT) && NP_busy;
      rdHoldSp <= rdWins && (rdPort == PORT_EXT) && SP_busy;
      if (rdGrant)
        rdPortQ <= rdPort;
    end
  end

  noPortClash: assert property (@(posedge clk) disable iff (rst)
    !(rdGrant && wrGrant && rdPort == wrPort));

endmodule

`default_nettype wire

// File: dmaTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmaCtrl_defs.svh"

module dmaTop
  import dmaPkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   regWrite,
  input  var  regSelT           regSel,
  input  wire [`DMA_ADR_W-1:0]  regData,
  output logic                  active,
  output logic                  done,
  output logic                  NP_en,
  output logic                  NP_wrRd,
  output logic [`DMA_ADR_W-1:0] NPA,
  output logic [`DMA_DATA_W-1:0] NPD_OUT,
  input  wire [`DMA_DATA_W-1:0] NPD_IN,
  input  wire                   NP_busy,
  output logic                  SP_en,
  output logic                  SP_wrRd,
  output logic [`DMA_ADR_W-1:0] SPA,
  output logic [`DMA_DATA_W-1:0] SPD_OUT,
  input  wire [`DMA_DATA_W-1:0] SPD_IN,
  input  wire                   SP_busy
);

  wire [`DMA_ADR_W-1:0]  srcIdx;
  wire [`DMA_ADR_W-1:0]  srcMod;
  wire [`DMA_ADR_W-1:0]  srcCnt;
  wire [`DMA_ADR_W-1:0]  dstIdx;
  wire [`DMA_ADR_W-1:0]  dstMod;
  wire [`DMA_ADR_W-1:0]  dstCnt;
  wire                   start;
  wire                   srcDone;
  wire                   dstDone;
  wire                   fifoEmpty;
  wire                   rdReq;
  wire                   rdGrant;
  portSelT               rdPort;
  wire [`DMA_ADR_W-1:0]  rdAdr;
  wire [`DMA_DATA_W-1:0] rdData;
  wire                   wrReq;
  wire                   wrGrant;
  portSelT               wrPort;
  wire [`DMA_ADR_W-1:0]  wrAdr;
  wire [`DMA_DATA_W-1:0] wrData;
  wire [`DMA_FIFO_DEPTH:0] stgValid;   // index 0 is the reader output
  wire [`DMA_FIFO_DEPTH:0] stgTake;    // index 0 is stage 0 ready
  wire [`DMA_DATA_W-1:0]   stgData [0:`DMA_FIFO_DEPTH];

  assign fifoEmpty = ~|stgValid[`DMA_FIFO_DEPTH:1];

  dmaRegFile regs (
    .clk(clk), .rst(rst), .regWrite(regWrite), .regSel(regSel), .regData(regData),
    .srcDone(srcDone), .dstDone(dstDone), .fifoEmpty(fifoEmpty),
    .srcIdx(srcIdx), .srcMod(srcMod), .srcCnt(srcCnt),
    .dstIdx(dstIdx), .dstMod(dstMod), .dstCnt(dstCnt),
    .start(start), .active(active), .done(done)
  );

  sourceReader reader (
    .clk(clk), .rst(rst), .start(start), .active(active),
    .srcIdx(srcIdx), .srcMod(srcMod), .srcCnt(srcCnt),
    .rdGrant(rdGrant), .portDataIn(rdData), .stageReady(stgTake[0]),
    .rdReq(rdReq), .rdPort(rdPort), .rdAdr(rdAdr),
    .inValid(stgValid[0]), .inData(stgData[0]), .srcDone(srcDone)
  );

  genvar k;
  generate
    for (k = 0; k < `DMA_FIFO_DEPTH; k++)
    begin : gStage
      fifoStage stage (
        .clk(clk), .rst(rst),
        .prevValid(stgValid[k]), .prevData(stgData[k]), .nextTake(stgTake[k+1]),
        .valid(stgValid[k+1]), .data(stgData[k+1]), .take(stgTake[k])
      );
    end
  endgenerate

  destWriter writer (
    .clk(clk), .rst(rst), .start(start), .active(active),
    .dstIdx(dstIdx), .dstMod(dstMod), .dstCnt(dstCnt),
    .headValid(stgValid[`DMA_FIFO_DEPTH]), .headData(stgData[`DMA_FIFO_DEPTH]),
    .wrGrant(wrGrant), .wrReq(wrReq), .wrPort(wrPort), .wrAdr(wrAdr),
    .wrData(wrData), .headTake(stgTake[`DMA_FIFO_DEPTH]), .dstDone(dstDone)
  );

  portArbiter arb (
    .clk(clk), .rst(rst),
    .rdReq(rdReq), .rdPort(rdPort), .rdAdr(rdAdr),
    .wrReq(wrReq), .wrPort(wrPort), .wrAdr(wrAdr), .wrData(wrData),
    .NP_busy(NP_busy), .SP_busy(SP_busy), .NPD_IN(NPD_IN), .SPD_IN(SPD_IN),
    .rdGrant(rdGrant), .wrGrant(wrGrant),
    .NP_en(NP_en), .NP_wrRd(NP_wrRd), .NPA(NPA), .NPD_OUT(NPD_OUT),
    .SP_en(SP_en), .SP_wrRd(SP_wrRd), .SPA(SPA), .SPD_OUT(SPD_OUT),
    .rdData(rdData)
  );

endmodule

`default_nettype wire

// File: memModel.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmaCtrl_defs.svh"

module memModel
(
  input  wire                    clk,
  input  wire                    en,
  input  wire                    wrRd,      // 1 means write
  input  wire [`DMA_ADR_W-1:0]   adr,
  input  wire [`DMA_DATA_W-1:0]  dataIn,
  input  wire                    busy,
  input  wire                    loadEn,    // backdoor preload
  input  wire [`DMA_ADR_W-1:0]   loadAdr,
  input  wire [`DMA_DATA_W-1:0]  loadData,
  output logic [`DMA_DATA_W-1:0] dataOut,
  output int                     acceptCount,
  output int                     writeCount
);

  logic [`DMA_DATA_W-1:0] mem [logic [`DMA_ADR_W-1:0]];

  // unwritten locations read back as a pattern of the full address
  function automatic logic [`DMA_DATA_W-1:0] fillWord(input logic [`DMA_ADR_W-1:0] a);
    return a ^ 16'h5a3c;
  endfunction

  initial
  begin
    dataOut     = '0;
    acceptCount = 0;
    writeCount  = 0;
  end

  always @(posedge clk)
  begin
    if (loadEn)
      mem[loadAdr] = loadData;
    if (en && !busy)
    begin
      acceptCount <= acceptCount + 1;
      if (wrRd)
      begin
        mem[adr] = dataIn;
        writeCount <= writeCount + 1;
      end
      else
        dataOut <= mem.exists(adr) ? mem[adr] : fillWord(adr); // valid next cycle
    end
  end

endmodule

`default_nettype wire

// File: dmaTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmaCtrl_defs.svh"

module dmaTb
  import dmaPkg::*;
();

  localparam int CLK_PERIOD      = 40;
  localparam int CYCLES_PER_WORD = 200;
  // 6 + 10 + 12 + 8 copied words, one extra slot each for reset and zero count
  localparam int TEST_WORDS      = 38;

  logic                   clk;
  logic                   rst;
  logic                   regWrite;
  regSelT                 regSel;
  logic [`DMA_ADR_W-1:0]  regData;
  logic                   active;
  logic                   done;
  logic                   npEn;
  logic                   npWrRd;
  logic [`DMA_ADR_W-1:0]  npAdr;
  logic [`DMA_DATA_W-1:0] npToMem;
  logic [`DMA_DATA_W-1:0] npFromMem;
  logic                   spEn;
  logic                   spWrRd;
  logic [`DMA_ADR_W-1:0]  spAdr;
  logic [`DMA_DATA_W-1:0] spToMem;
  logic [`DMA_DATA_W-1:0] spFromMem;
  logic                   npBusy;
  logic                   spBusy;
  logic                   randBusy;
  logic                   npLoadEn;
  logic                   spLoadEn;
  logic [`DMA_ADR_W-1:0]  loadAdr;
  logic [`DMA_DATA_W-1:0] loadData;
  logic [31:0]            busyRnd;
  int                     npAccepts;
  int                     npWrites;
  int                     spAccepts;
  int                     spWrites;
  int                     seed = 79784;
  int                     errors = 0;
  int                     failedTests = 0;
  int                     doneCount = 0;
  logic [`DMA_DATA_W-1:0] expWords [$];

  dmaTop i_dut (
    .clk(clk), .rst(rst), .regWrite(regWrite), .regSel(regSel), .regData(regData),
    .active(active), .done(done),
    .NP_en(npEn), .NP_wrRd(npWrRd), .NPA(npAdr), .NPD_OUT(npToMem),
    .NPD_IN(npFromMem), .NP_busy(npBusy),
    .SP_en(spEn), .SP_wrRd(spWrRd), .SPA(spAdr), .SPD_OUT(spToMem),
    .SPD_IN(spFromMem), .SP_busy(spBusy)
  );

  memModel npMem (
    .clk(clk), .en(npEn), .wrRd(npWrRd), .adr(npAdr), .dataIn(npToMem), .busy(npBusy),
    .loadEn(npLoadEn), .loadAdr(loadAdr), .loadData(loadData),
    .dataOut(npFromMem), .acceptCount(npAccepts), .writeCount(npWrites)
  );

  memModel spMem (
    .clk(clk), .en(spEn), .wrRd(spWrRd), .adr(spAdr), .dataIn(spToMem), .busy(spBusy),
    .loadEn(spLoadEn), .loadAdr(loadAdr), .loadData(loadData),
    .dataOut(spFromMem), .acceptCount(spAccepts), .writeCount(spWrites)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (done)
      doneCount <= doneCount + 1;
  end

  always @(negedge clk)
  begin
    if (randBusy)
    begin
      busyRnd = $random(seed);
      spBusy  = busyRnd[0]; // about half the cycles stalled
    end
    else
      spBusy = 1'b0;
  end

  initial
  begin
    repeat (CYCLES_PER_WORD * TEST_WORDS) @(posedge clk);
    $display("watchdog expired after %0d cycles", CYCLES_PER_WORD * TEST_WORDS);
    $display("test failed");
    $finish;
  end

  // top nibble F is the internal port
  function automatic portSelT portOf(input logic [`DMA_ADR_W-1:0] a);
    return (a[15:12] == 4'hF) ? PORT_INT : PORT_EXT;
  endfunction

  function automatic logic [`DMA_DATA_W-1:0] readMem(input logic [`DMA_ADR_W-1:0] a);
    if (portOf(a) == PORT_INT)
      return npMem.mem[a];
    return spMem.mem[a];
  endfunction

  task automatic checkValue(input string name, input int got, input int exp);
    assert (got == exp)
    else
    begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finishTest(input string name, input int errStart);
    if (errors == errStart)
      $display("%s: ok", name);
    else
    begin
      $display("%s: %0d errors", name, errors - errStart);
      failedTests++;
    end
  endtask

  // entered and left on a falling edge
  task automatic writeReg(input regSelT sel, input logic [`DMA_ADR_W-1:0] value);
    regWrite = 1'b1;
    regSel   = sel;
    regData  = value;
    @(negedge clk);
    regWrite = 1'b0;
  endtask

  task automatic loadSource(input logic [15:0] idx, input logic [15:0] step, input int count);
    logic [`DMA_ADR_W-1:0] adr;
    logic [31:0]           rnd;
    expWords.delete();
    adr = idx;
    for (int i = 0; i < count; i++)
    begin
      rnd = $random(seed);
      expWords.push_back(rnd[15:0]);
      npLoadEn = (portOf(adr) == PORT_INT);
      spLoadEn = (portOf(adr) == PORT_EXT);
      loadAdr  = adr;
      loadData = rnd[15:0];
      @(negedge clk);
      adr = adr + step;
    end
    npLoadEn = 1'b0;
    spLoadEn = 1'b0;
  endtask

  task automatic startTransfer(input logic [15:0] sIdx, input logic [15:0] sMod,
                               input logic [15:0] dIdx, input logic [15:0] dMod,
                               input logic [15:0] count);
    writeReg(REG_SRC_IDX, sIdx);
    writeReg(REG_SRC_MOD, sMod);
    writeReg(REG_SRC_CNT, count);
    writeReg(REG_DST_IDX, dIdx);
    writeReg(REG_DST_MOD, dMod);
    writeReg(REG_DST_CNT, count);
    writeReg(REG_CTRL, 16'h0001);
  endtask

  task automatic waitDone(input int words);
    bit seen;
    int limit;
    seen  = 1'b0;
    limit = CYCLES_PER_WORD * words + 50;
    for (int c = 0; c < limit && !seen; c++)
    begin
      @(negedge clk);
      seen = done;
    end
    assert (seen)
    else
    begin
      $display("done did not pulse within %0d cycles", limit);
      errors++;
    end
  endtask

  // destination word i must equal source word i
  task automatic runCopy(input logic [15:0] sIdx, input logic [15:0] sMod,
                         input logic [15:0] dIdx, input logic [15:0] dMod, input int count);
    logic [`DMA_ADR_W-1:0] adr;
    loadSource(sIdx, sMod, count);
    startTransfer(sIdx, sMod, dIdx, dMod, count[15:0]);
    waitDone(count);
    checkValue("active", active, 0);
    adr = dIdx;
    foreach (expWords[i])
    begin
      assert (readMem(adr) === expWords[i])
      else
      begin
        $display("Mismatch mem[%h]: got %h, expected %h", adr, readMem(adr), expWords[i]);
        errors++;
      end
      adr = adr + dMod;
    end
  endtask

  task automatic testReset();
    int errStart;
    errStart = errors;
    for (int c = 0; c < 8; c++)
    begin
      checkValue("NP_en", npEn, 0);
      checkValue("SP_en", spEn, 0);
      checkValue("NP_wrRd", npWrRd, 0);
      checkValue("SP_wrRd", spWrRd, 0);
      checkValue("done", done, 0);
      @(negedge clk);
    end
    checkValue("NP writes", npWrites, 0);
    checkValue("SP writes", spWrites, 0);
    finishTest("reset", errStart);
  endtask

  task automatic testIntToInt();
    int errStart;
    errStart = errors;
    runCopy(16'hF000, 16'd1, 16'hF100, 16'd1, 6); // both sides share NP
    finishTest("internal to internal", errStart);
  endtask

  task automatic testCrossPorts();
    int errStart;
    errStart = errors;
    runCopy(16'hF200, 16'd2, 16'h2000, 16'd3, 5);
    runCopy(16'h2100, 16'd2, 16'hF300, 16'd3, 5);
    finishTest("internal to external and back", errStart);
  endtask

  task automatic testExtToExt();
    int errStart;
    int writesBefore;
    int acceptsBefore;
    errStart      = errors;
    writesBefore  = spWrites;
    acceptsBefore = spAccepts;
    randBusy = 1'b1;
    runCopy(16'h4000, 16'd1, 16'h5000, 16'd1, 12);
    randBusy = 1'b0;
    checkValue("SP writes", spWrites - writesBefore, 12);
    checkValue("SP accepts", spAccepts - acceptsBefore, 24); // 12 reads and 12 writes
    finishTest("external to external with busy", errStart);
  endtask

  task automatic testZeroCount();
    int errStart;
    int acceptsBefore;
    errStart      = errors;
    acceptsBefore = npAccepts + spAccepts;
    startTransfer(16'hF400, 16'd1, 16'hF500, 16'd1, 16'd0);
    waitDone(0);
    checkValue("accepts", npAccepts + spAccepts - acceptsBefore, 0);
    finishTest("zero count", errStart);
  endtask

  task automatic testAbort();
    int errStart;
    int doneBefore;
    int writesBefore;
    int acceptsAfter;
    errStart     = errors;
    loadSource(16'hF600, 16'd1, 8);
    doneBefore   = doneCount;
    writesBefore = spWrites;
    startTransfer(16'hF600, 16'd1, 16'h6000, 16'd1, 16'd8);
    for (int c = 0; c < CYCLES_PER_WORD && spWrites < writesBefore + 2; c++)
      @(negedge clk);
    writeReg(REG_CTRL, 16'h0000);
    acceptsAfter = npAccepts + spAccepts;
    repeat (10) @(negedge clk);
    checkValue("active", active, 0);
    checkValue("accepts after abort", npAccepts + spAccepts - acceptsAfter, 0);
    checkValue("done pulses", doneCount - doneBefore, 0);
    finishTest("abort", errStart);
  endtask

  initial
  begin
    rst      = 1'b1;
    regWrite = 1'b0;
    regSel   = REG_CTRL;
    regData  = '0;
    npBusy   = 1'b0;
    spBusy   = 1'b0;
    randBusy = 1'b0;
    npLoadEn = 1'b0;
    spLoadEn = 1'b0;
    loadAdr  = '0;
    loadData = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    testReset();
    testIntToInt();
    testCrossPorts();
    testExtToExt();
    testZeroCount();
    testAbort();
    $display("tests run 6, tests failed %0d, errors %0d", failedTests, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
dmaPkg.sv
dmaRegFile.sv
fifoStage.sv
sourceReader.sv
destWriter.sv
portArbiter.sv
dmaTop.sv
memModel.sv
dmaTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dmaTb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
PASS_MSG = test passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
